// ==== Makefile ====
# Verilator build and run for the operand queue

VERILATOR ?= verilator
TOP       ?= operand_queue_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/operand_queue.sv ====
// Vector lane operand queue

`timescale 1ns/1ps

module operand_queue import opq_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Operand requester commands
  input  opq_cmd_t               cmd_i,
  input  logic                   cmd_valid_i,
  // Register file words
  input  elen_t                  operand_i,
  input  logic                   operand_valid_i,
  input  logic                   operand_issued_i,
  output logic                   operand_queue_ready_o,
  // Functional units
  output opq_operand_t           operand_o,
  output logic                   operand_valid_o,
  input  logic [NrConsumers-1:0] operand_ready_i
);

  opq_cmd_t        cmd;
  elen_t           data;
  elen_t           conv_data;
  logic            cmd_empty, data_empty;
  logic            cmd_pop, data_pop;
  logic [SelW-1:0] select;

  //////////////////////////////////////////////////////////////////////
  // Buffers
  //////////////////////////////////////////////////////////////////////

  opq_fifo #(
    .payload_t(opq_cmd_t),
    .Depth    (CmdBufDepth)
  ) i_cmd_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_valid_i),
    .data_i (cmd_i),
    .pop_i  (cmd_pop),
    .data_o (cmd),
    .empty_o(cmd_empty),
    .full_o ()
  );

  opq_fifo #(
    .payload_t(elen_t),
    .Depth    (DataBufDepth)
  ) i_data_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (data_pop),
    .data_o (data),
    .empty_o(data_empty),
    .full_o ()
  );

  // Credits keep the data buffer from overflowing
  opq_credit_counter i_credit_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .issued_i  (operand_issued_i),
    .consumed_i(data_pop),
    .ready_o   (operand_queue_ready_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Conversion and sequencing
  //////////////////////////////////////////////////////////////////////

  opq_extender i_extender (
    .operand_i(data),
    .conv_i   (cmd.conv),
    .eew_i    (cmd.eew),
    .select_i (select),
    .operand_o(conv_data)
  );

  opq_sequencer i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd),
    .cmd_empty_i    (cmd_empty),
    .data_empty_i   (data_empty),
    .operand_ready_i(operand_ready_i),
    .operand_valid_o(operand_valid_o),
    .select_o       (select),
    .cmd_pop_o      (cmd_pop),
    .data_pop_o     (data_pop)
  );

  assign operand_o.data      = conv_data;
  assign operand_o.target_fu = cmd.target_fu;

endmodule : operand_queue

// ==== logic/opq_credit_counter.sv ====
// Data buffer credit counter

`timescale 1ns/1ps

module opq_credit_counter import opq_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic issued_i,
  input  logic consumed_i,
  output logic ready_o
);

  // Words issued to the register file and not yet popped
  logic [$clog2(DataBufDepth + 1)-1:0] credit_d, credit_q;

  always_comb begin : p_credit
    credit_d = credit_q;
    if (issued_i && !consumed_i) begin
      credit_d = credit_q + 1'b1;
    end else if (consumed_i && !issued_i) begin
      credit_d = credit_q - 1'b1;
    end
  end : p_credit

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_credit_ff
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end : p_credit_ff

  // Another issue is allowed while a buffer slot is still free
  assign ready_o = (credit_q < DataBufDepth);

endmodule : opq_credit_counter

// ==== logic/opq_extender.sv ====
// Integer widening of operand words

`timescale 1ns/1ps

module opq_extender import opq_pkg::*; (
  input  elen_t           operand_i,
  input  opq_conv_e       conv_i,
  input  ew_e             eew_i,
  input  logic [SelW-1:0] select_i,
  output elen_t           operand_o
);

  // Selected part of the word, lowest source element at bit 0
  elen_t src;
  logic  sext;

  assign src  = operand_i >> {select_i, 3'b000};
  assign sext = (conv_i == ConvSExt2) || (conv_i == ConvSExt4) || (conv_i == ConvSExt8);

  always_comb begin : p_widen
    // Pass-through unless a widening is requested
    operand_o = operand_i;

    unique case (conv_i)
      ConvSExt2, ConvZExt2: begin
        unique case (eew_i)
          EW8: begin
            for (int e = 0; e < 4; e++) begin
              operand_o[16*e +: 16] = {{8{sext && src[8*e+7]}}, src[8*e +: 8]};
            end
          end
          EW16: begin
            for (int e = 0; e < 2; e++) begin
              operand_o[32*e +: 32] = {{16{sext && src[16*e+15]}}, src[16*e +: 16]};
            end
          end
          EW32: operand_o = {{32{sext && src[31]}}, src[31:0]};
          default: ;
        endcase
      end

      ConvSExt4, ConvZExt4: begin
        unique case (eew_i)
          EW8: begin
            for (int e = 0; e < 2; e++) begin
              operand_o[32*e +: 32] = {{24{sext && src[8*e+7]}}, src[8*e +: 8]};
            end
          end
          EW16: operand_o = {{48{sext && src[15]}}, src[15:0]};
          default: ;
        endcase
      end

      // Only bytes can grow by eight
      ConvSExt8, ConvZExt8: begin
        if (eew_i == EW8) begin
          operand_o = {{56{sext && src[7]}}, src[7:0]};
        end
      end

      default: ;
    endcase
  end : p_widen

endmodule : opq_extender

// ==== logic/opq_fifo.sv ====
// Synchronous circular buffer

`timescale 1ns/1ps

module opq_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] usage_q;
  logic            do_push, do_pop;

  // Guard against overrun and underrun
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == CntW'(Depth));

  // Head of the queue, not fall-through
  assign data_o = mem_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == PtrW'(Depth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == PtrW'(Depth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Occupancy only moves when exactly one side acts
      if (do_push && !do_pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (do_pop && !do_push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end : p_ctrl

  // Storage
  always_ff @(posedge clk_i) begin : p_mem
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end : p_mem

endmodule : opq_fifo

// ==== logic/opq_pkg.sv ====
// Operand queue definitions

package opq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and depths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ElenW = 64;
  localparam int unsigned ElenBytes = 8;
  localparam int unsigned SelW = 3;
  localparam int unsigned VlW = 16;

  localparam int unsigned CmdBufDepth = 2;
  localparam int unsigned DataBufDepth = 2;

  // Functional units that may take an operand
  localparam int unsigned NrConsumers = 2;

  //////////////////////////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ElenW-1:0] elen_t;
  typedef logic [VlW-1:0] vlen_t;

  // Source element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  typedef enum logic [2:0] {
    ConvNone  = 3'd0,
    ConvSExt2 = 3'd1,
    ConvSExt4 = 3'd2,
    ConvSExt8 = 3'd3,
    ConvZExt2 = 3'd4,
    ConvZExt4 = 3'd5,
    ConvZExt8 = 3'd6
  } opq_conv_e;

  typedef enum logic {
    FuAluSldu     = 1'b0,
    FuMfpuAddrgen = 1'b1
  } target_fu_e;

  //////////////////////////////////////////////////////////////////////
  // Command and operand
  //////////////////////////////////////////////////////////////////////

  // One command from the operand requester
  typedef struct packed {
    opq_conv_e  conv;
    ew_e        eew;
    target_fu_e target_fu;
    vlen_t      vl;
  } opq_cmd_t;

  // Word handed to the functional units
  typedef struct packed {
    elen_t      data;
    target_fu_e target_fu;
  } opq_operand_t;

endpackage : opq_pkg

// ==== logic/opq_sequencer.sv ====
// Operand queue output sequencer

`timescale 1ns/1ps

module opq_sequencer import opq_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  opq_cmd_t               cmd_i,
  input  logic                   cmd_empty_i,
  input  logic                   data_empty_i,
  input  logic [NrConsumers-1:0] operand_ready_i,
  output logic                   operand_valid_o,
  output logic [SelW-1:0]        select_o,
  output logic                   cmd_pop_o,
  output logic                   data_pop_o
);

  logic [SelW-1:0] select_d, select_q;
  vlen_t           elem_cnt_d, elem_cnt_q;
  logic [1:0]      widen_log2;
  logic [SelW:0]   step;
  logic [SelW:0]   select_sum;
  vlen_t           elems;
  logic [VlW:0]    cnt_sum;
  logic            transfer;

  //////////////////////////////////////////////////////////////////////
  // Output handshake
  //////////////////////////////////////////////////////////////////////

  assign operand_valid_o = !cmd_empty_i && !data_empty_i;
  assign transfer        = operand_valid_o && |operand_ready_i;
  assign select_o        = select_q;

  // log2 of the widening factor
  always_comb begin : p_factor
    unique case (cmd_i.conv)
      ConvSExt2, ConvZExt2: widen_log2 = 2'd1;
      ConvSExt4, ConvZExt4: widen_log2 = 2'd2;
      ConvSExt8, ConvZExt8: widen_log2 = 2'd3;
      default:              widen_log2 = 2'd0;
    endcase
  end : p_factor

  // Bytes of the source word used per output word, a full word for pass-through
  assign step = (SelW + 1)'(ElenBytes) >> widen_log2;
  // Elements carried by each output word
  assign elems = vlen_t'(ElenBytes) >> ({1'b0, cmd_i.eew} + {1'b0, widen_log2});

  // Carry out of the select marks a consumed source word
  assign select_sum = {1'b0, select_q} + step;
  assign cnt_sum    = {1'b0, elem_cnt_q} + {1'b0, elems};

  //////////////////////////////////////////////////////////////////////
  // Advance, pop and end of command
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_seq
    select_d   = select_q;
    elem_cnt_d = elem_cnt_q;
    cmd_pop_o  = 1'b0;
    data_pop_o = 1'b0;

    if (transfer) begin
      select_d   = select_sum[SelW-1:0];
      elem_cnt_d = cnt_sum[VlW-1:0];
      data_pop_o = select_sum[SelW];

      // Command done, drop the rest of the word as well
      if (cnt_sum >= {1'b0, cmd_i.vl}) begin
        cmd_pop_o  = 1'b1;
        data_pop_o = 1'b1;
        select_d   = '0;
        elem_cnt_d = '0;
      end
    end
  end : p_seq

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_seq_ff
    if (!rst_ni) begin
      select_q   <= '0;
      elem_cnt_q <= '0;
    end else begin
      select_q   <= select_d;
      elem_cnt_q <= elem_cnt_d;
    end
  end : p_seq_ff

endmodule : opq_sequencer

// ==== verification/operand_queue_assert.sv ====
// Buffer protocol assertions

`timescale 1ns/1ps

module operand_queue_assert #(
  parameter type payload_t = logic
) (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     push_i,
  input logic     pop_i,
  input payload_t head_i,
  input logic     empty_i,
  input logic     full_i
);

  // Writer must respect the occupancy
  a_push_not_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_i
  ) else $error("buffer pushed while full");

  a_pop_not_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_i
  ) else $error("buffer popped while empty");

  // Oldest entry may only leave through a pop
  a_head_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (!empty_i && !pop_i) |=> $stable(head_i)
  ) else $error("buffer head changed without a pop");

endmodule : operand_queue_assert

// ==== verification/operand_queue_tb.sv ====
// Operand queue testbench

`timescale 1ns/1ps

module operand_queue_tb import opq_pkg::*; ();

  localparam int unsigned NumCmds       = 300;
  localparam int unsigned MaxVl         = 40;
  localparam int unsigned TimeoutCycles = NumCmds * MaxVl * 8;

  logic                   clk_i;
  logic                   rst_ni;
  opq_cmd_t               cmd_i;
  logic                   cmd_valid_i;
  elen_t                  operand_i;
  logic                   operand_valid_i;
  logic                   operand_issued_i;
  logic                   operand_queue_ready_o;
  opq_operand_t           operand_o;
  logic                   operand_valid_o;
  logic [NrConsumers-1:0] operand_ready_i;

  logic [31:0]  rng_state = 32'hde31;
  opq_operand_t exp_q[$];
  int unsigned  outs_q[$];
  elen_t        issue_q[$];
  elen_t        deliver_q[$];
  int unsigned  cmds_sent = 0;
  int unsigned  cmds_done = 0;
  int unsigned  cycle_cnt = 0;
  logic         saw_ready_low = 1'b0;
  logic         ready_recovered = 1'b0;
  logic         holding = 1'b0;
  opq_operand_t held;

  operand_queue dut (.*);

  bind opq_fifo operand_queue_assert #(.payload_t(payload_t)) i_fifo_assert (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push_i),
    .pop_i  (pop_i),
    .head_i (data_o),
    .empty_i(empty_o),
    .full_i (full_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int unsigned widen_log2(input opq_conv_e conv);
    case (conv)
      ConvSExt2, ConvZExt2: return 1;
      ConvSExt4, ConvZExt4: return 2;
      ConvSExt8, ConvZExt8: return 3;
      default:              return 0;
    endcase
  endfunction

  function automatic bit sign_extends(input opq_conv_e conv);
    return (conv == ConvSExt2) || (conv == ConvSExt4) || (conv == ConvSExt8);
  endfunction

  // Widened elements taken from byte sel_byte on, lowest element first
  function automatic elen_t expected_word(input elen_t word, input int unsigned sb,
                                          input int unsigned f, input bit sgn,
                                          input int unsigned sel_byte);
    elen_t       res;
    int unsigned src_bits;
    int unsigned dst_bits;
    int unsigned idx;
    logic        b_val;
    res      = '0;
    src_bits = 8 * sb;
    dst_bits = src_bits * f;
    for (int unsigned e = 0; e < ElenW / dst_bits; e++) begin
      for (int unsigned b = 0; b < dst_bits; b++) begin
        idx   = 8 * sel_byte + e * src_bits + ((b < src_bits) ? b : src_bits - 1);
        b_val = word[idx];
        if (b >= src_bits && !sgn) begin
          b_val = 1'b0;
        end
        res[e * dst_bits + b] = b_val;
      end
    end
    return res;
  endfunction

  task automatic compare_values(input logic [ElenW:0] actual, input logic [ElenW:0] expected,
                                input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Strobe a random legal command and queue its words and expected outputs
  task automatic queue_command();
    opq_cmd_t     cmd;
    opq_operand_t exp;
    elen_t        words[$];
    int unsigned  lg;
    int unsigned  f;
    int unsigned  sb;
    int unsigned  epw;
    int unsigned  nout;
    int unsigned  nwords;
    cmd.conv      = opq_conv_e'(3'(next_rand() % 7));
    lg            = widen_log2(cmd.conv);
    f             = 1 << lg;
    cmd.eew       = ew_e'(2'(next_rand() % (4 - lg)));
    cmd.target_fu = target_fu_e'(1'(next_rand()));
    cmd.vl        = vlen_t'(1 + next_rand() % MaxVl);
    sb            = 1 << cmd.eew;
    epw           = ElenBytes / (sb * f);
    nout          = (cmd.vl + epw - 1) / epw;
    nwords        = (nout + f - 1) / f;
    for (int unsigned w = 0; w < nwords; w++) begin
      words.push_back({next_rand(), next_rand()});
      issue_q.push_back(words[w]);
    end
    for (int unsigned k = 0; k < nout; k++) begin
      exp.data      = expected_word(words[k / f], sb, f, sign_extends(cmd.conv),
                                    (k % f) * (ElenBytes / f));
      exp.target_fu = cmd.target_fu;
      exp_q.push_back(exp);
    end
    outs_q.push_back(nout);
    cmd_i       = cmd;
    cmd_valid_i = 1'b1;
    cmds_sent++;
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    cmd_valid_i      = 1'b0;
    operand_issued_i = 1'b0;
    operand_valid_i  = 1'b0;
    // Roughly 30% of cycles without any consumer ready
    r = next_rand();
    operand_ready_i = (r % 10 < 3) ? '0 : NrConsumers'(1 + (r >> 8) % 3);
    if (deliver_q.size() > 0 && next_rand() % 4 != 0) begin
      operand_i       = deliver_q.pop_front();
      operand_valid_i = 1'b1;
    end
    if (issue_q.size() > 0 && operand_queue_ready_o && next_rand() % 3 != 0) begin
      operand_issued_i = 1'b1;
      deliver_q.push_back(issue_q.pop_front());
    end
    if (issue_q.size() == 0 && cmds_sent < NumCmds &&
        cmds_sent - cmds_done < CmdBufDepth && next_rand() % 2 == 0) begin
      queue_command();
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    rst_ni           = 1'b0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    compare_values(operand_valid_o, 1'b0, "output valid during reset");
    compare_values(operand_queue_ready_o, 1'b1, "queue ready during reset");
    rst_ni = 1'b1;
    while (!(cmds_sent == NumCmds && exp_q.size() == 0)) begin
      @(negedge clk_i);
      drive_cycle();
    end
    @(negedge clk_i);
    cmd_valid_i      = 1'b0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    // All consumers ready, so a stray output word would transfer
    operand_ready_i  = '1;
    repeat (5) @(negedge clk_i);
    compare_values(saw_ready_low, 1'b1, "queue ready never observed low");
    compare_values(ready_recovered, 1'b1, "queue ready never returned high");
    if (operand_valid_o || !operand_queue_ready_o) begin
      $display("error: queue still holds words or credits after all commands completed");
      $display("Simulation finished: FAIL");
      $fatal(1);
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : p_monitor
    opq_operand_t expected;
    if (rst_ni) begin
      if (!operand_queue_ready_o) begin
        saw_ready_low = 1'b1;
      end else if (saw_ready_low) begin
        ready_recovered = 1'b1;
      end
      // Output frozen while stalled
      if (holding) begin
        compare_values(operand_valid_o, 1'b1, "valid dropped under back-pressure");
        compare_values(operand_o, held, "operand changed under back-pressure");
      end
      holding = operand_valid_o && (operand_ready_i == '0);
      held    = operand_o;
      if (operand_valid_o && |operand_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("error: output transfer at %0t ns with no word expected", $time);
          $display("Simulation finished: FAIL");
          $fatal(1);
        end
        expected = exp_q.pop_front();
        compare_values(operand_o, expected, $sformatf("output of command %0d", cmds_done));
        outs_q[0] = outs_q[0] - 1;
        if (outs_q[0] == 0) begin
          void'(outs_q.pop_front());
          cmds_done++;
        end
      end
    end
  end

  always @(posedge clk_i) begin : p_timeout
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("error: run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

endmodule : operand_queue_tb

// ==== vlog.f ====
logic/opq_pkg.sv
logic/opq_fifo.sv
logic/opq_credit_counter.sv
logic/opq_extender.sv
logic/opq_sequencer.sv
logic/operand_queue.sv
verification/operand_queue_assert.sv
verification/operand_queue_tb.sv
